// File: ethSwitch.f
+incdir+hw
hw/ethSwitchPkg.sv
hw/frameReceiver.sv
hw/forwardTable.sv
hw/packetFifo.sv
hw/txScheduler.sv
hw/ethSwitch.sv
tb/ethSwitchTb.sv

// File: hw/ethSwitch.sv
// Four-port frame switch, single clock domain
// Port order: Eth1, Eth2, PS, RT; no back-pressure on rx or tx
// Input frames must be at least 12 idle cycles apart
`timescale 1ns/1ps
`include "ethSwitch_defs.svh"

module ethSwitch (
  input  logic                  RxClk,
  input  logic                  rstN,
  input  ethSwitchPkg::rxByteS  rx [`NUM_PORTS],
  input  logic [`NUM_PORTS-1:0] portActive,
  input  logic [3:0]            boardId,
  output ethSwitchPkg::txByteS  tx [`NUM_PORTS]
);

  localparam int N = `NUM_PORTS;

  ethSwitchPkg::switchWordS stream  [N];
  ethSwitchPkg::macAddrU    destMac [N];
  ethSwitchPkg::macAddrU    srcMac  [N];
  logic [N-1:0]             headerDone;
  logic [N-1:0]             fwdMask  [N];    // [in] bit out
  ethSwitchPkg::switchWordS fifoWord [N][N]; // [out][in]
  logic [N-1:0]             pktAvail [N];    // [out] bit in
  logic [N-1:0]             rdEn     [N];    // [out] bit in

  for (genvar p = 0; p < N; p++) begin : gRx
    frameReceiver uRx (
      .RxClk      (RxClk),
      .rstN       (rstN),
      .rx         (rx[p]),
      .stream     (stream[p]),
      .destMac    (destMac[p]),
      .srcMac     (srcMac[p]),
      .headerDone (headerDone[p])
    );
  end

  forwardTable uTable (
    .RxClk      (RxClk),
    .rstN       (rstN),
    .boardId    (boardId),
    .portActive (portActive),
    .destMac    (destMac),
    .srcMac     (srcMac),
    .headerDone (headerDone),
    .fwdMask    (fwdMask)
  );

  // One FIFO per in/out pair, none on the diagonal
  for (genvar i = 0; i < N; i++) begin : gIn
    for (genvar o = 0; o < N; o++) begin : gOut
      if (i == o) begin : gDiag
        assign fifoWord[o][i] = '0;
        assign pktAvail[o][i] = 1'b0;
      end else begin : gPair
        packetFifo uFifo (
          .RxClk    (RxClk),
          .rstN     (rstN),
          .flush    (~portActive[o]),
          .wrEn     (stream[i].valid & fwdMask[i][o]),
          .wrWord   (stream[i]),
          .rdEn     (rdEn[o][i]),
          .rdWord   (fifoWord[o][i]),
          .pktAvail (pktAvail[o][i])
        );
      end
    end
  end

  for (genvar o = 0; o < N; o++) begin : gTx
    txScheduler uTx (
      .RxClk    (RxClk),
      .rstN     (rstN),
      .pktAvail (pktAvail[o]),
      .rdWord   (fifoWord[o]),
      .rdEn     (rdEn[o]),
      .tx       (tx[o])
    );
  end

endmodule

// File: hw/ethSwitchPkg.sv
// Types shared by the switch blocks
// Struct field order sets the packed bit layout, keep it stable
`include "ethSwitch_defs.svh"

package ethSwitchPkg;

  // Status carried with every switched byte
  typedef enum logic [1:0] {
    ST_PLAIN = 2'b00,
    ST_FIRST = 2'b01,
    ST_LAST  = 2'b10,
    ST_ERR   = 2'b11
  } byteStE;

  // Receive side of one port, one byte per valid cycle
  typedef struct packed {
    logic              valid;
    logic [`BYTE_W-1:0] data;
    logic              err;
  } rxByteS;

  typedef struct packed {
    logic              en;
    logic [`BYTE_W-1:0] data;
    logic              err;
  } txByteS;

  // One FIFO entry
  typedef struct packed {
    logic              valid;
    byteStE            st;
    logic [`BYTE_W-1:0] data;
  } switchWordS;

  typedef struct packed {
    logic [23:0] cid;    // Company ID
    logic [15:0] iface;  // PS or RT
    logic [3:0]  pad;
    logic [3:0]  board;
  } fpgaMacS;

  // Same 48 bits, raw or split into FPGA fields
  typedef union packed {
    logic [47:0] raw;
    fpgaMacS     fpga;
  } macAddrU;

endpackage

// File: hw/ethSwitch_defs.svh
// Sizing and address constants for the four-port switch
// Port indices fix which ports learn host and FPGA addresses (Eth1, Eth2)
// FIFO_DEPTH must hold the largest frame, since there is no drop path
`ifndef ETH_SWITCH_DEFS_SVH
`define ETH_SWITCH_DEFS_SVH

`define NUM_PORTS     4
`define BYTE_W        8
`define HDR_BYTES     14          // Ethernet header, also the Rx delay-line depth
`define FIFO_DEPTH    128         // Bytes per in/out pair
`define IPG_BYTES     12          // Interpacket gap

`define SFD_BYTE      8'hd5

// FPGA MAC layout: company ID, interface, pad, board
`define LCSR_CID      24'hfa610e
`define CID_MULTICAST (`LCSR_CID | 24'h010000)
`define PS_IFACE      16'h0300
`define RT_IFACE      16'h1394

`define BROADCAST_MAC 48'hffffffffffff

// Port map
`define ETH1_IDX      0
`define ETH2_IDX      1
`define PS_IDX        2
`define RT_IDX        3

`endif

// File: hw/forwardTable.sv
// Learns host MAC and visible FPGA boards on Eth1/Eth2, builds forward masks
// Masks are combinational from the held destination address
// Learned entries clear while their port is inactive
`timescale 1ns/1ps
`include "ethSwitch_defs.svh"

module forwardTable (
  input  logic                       RxClk,
  input  logic                       rstN,
  input  logic [3:0]                 boardId,
  input  logic [`NUM_PORTS-1:0]      portActive,
  input  ethSwitchPkg::macAddrU      destMac [`NUM_PORTS],
  input  ethSwitchPkg::macAddrU      srcMac  [`NUM_PORTS],
  input  logic [`NUM_PORTS-1:0]      headerDone,
  output logic [`NUM_PORTS-1:0]      fwdMask [`NUM_PORTS]
);

  localparam int N = `NUM_PORTS;

  logic [47:0] hostMac  [`ETH1_IDX:`ETH2_IDX];   // Learned host per Eth port
  logic [15:0] fpgaSeen [`ETH1_IDX:`ETH2_IDX];   // Boards seen behind each Eth port
  logic [15:0] fpgaAct  [`ETH1_IDX:`ETH2_IDX];   // Forward board traffic on this port
  logic [15:0] unseen;                           // Board seen on neither port
  logic [47:0] primary  [N];                     // Primary address per out-port

  // Learning, Eth ports only
  always_ff @(posedge RxClk) begin
    for (int p = `ETH1_IDX; p <= `ETH2_IDX; p++) begin
      if (!rstN || !portActive[p]) begin
        hostMac[p]  <= `BROADCAST_MAC;
        fpgaSeen[p] <= '0;
      end else if (headerDone[p]) begin
        hostMac[p] <= srcMac[p].raw;
        // Interface field does not matter here, any board address counts
        if (srcMac[p].fpga.cid == `LCSR_CID) begin
          fpgaSeen[p][srcMac[p].fpga.board] <= 1'b1;
        end
      end
    end
  end

  always_comb begin
    for (int b = 0; b < 16; b++) begin
      // Flood unknown boards, but never our own
      unseen[b] = ~fpgaSeen[`ETH1_IDX][b] & ~fpgaSeen[`ETH2_IDX][b] & (boardId != 4'(b));
    end
    for (int p = `ETH1_IDX; p <= `ETH2_IDX; p++) begin
      fpgaAct[p] = fpgaSeen[p] | unseen;
    end
  end

  always_comb begin
    primary[`ETH1_IDX] = hostMac[`ETH1_IDX];
    primary[`ETH2_IDX] = hostMac[`ETH2_IDX];
    primary[`PS_IDX]   = {`LCSR_CID, `PS_IFACE, 4'd0, boardId};
    primary[`RT_IDX]   = {`LCSR_CID, `RT_IFACE, 4'd0, boardId};
  end

  for (genvar i = 0; i < N; i++) begin : gIn
    logic         isBcast;
    logic         isMcast;
    logic         isCid;
    logic         noMatch;
    wire  [N-1:0] primHit;
    wire  [N-1:0] fpgaHit;
    wire  [N-1:0] mask;

    assign isBcast = destMac[i].raw == `BROADCAST_MAC;
    assign isMcast = (destMac[i].fpga.cid == `CID_MULTICAST) &&
                     ({destMac[i].fpga.pad, destMac[i].fpga.board} == 8'hff);
    assign isCid   = destMac[i].fpga.cid == `LCSR_CID;
    assign noMatch = ~(|primHit) & ~(|fpgaHit);   // Unknown anywhere, flood to Eth

    for (genvar o = 0; o < N; o++) begin : gOut
      if (o == i) begin : gSelf
        assign primHit[o] = 1'b0;
        assign fpgaHit[o] = 1'b0;
        assign mask[o]    = 1'b0;                 // No hairpin
      end else if (o == `ETH1_IDX || o == `ETH2_IDX) begin : gEth
        assign primHit[o] = destMac[i].raw == primary[o];
        assign fpgaHit[o] = isCid & fpgaAct[o][destMac[i].fpga.board];
        assign mask[o]    = portActive[o] &
                            (isBcast | isMcast | primHit[o] | fpgaHit[o] | noMatch);
      end else begin : gClient
        assign primHit[o] = destMac[i].raw == primary[o];
        assign fpgaHit[o] = 1'b0;                 // Clients take only their own address
        assign mask[o]    = portActive[o] & (isBcast | isMcast | primHit[o]);
      end
    end

    assign fwdMask[i] = mask;

    // Never back to the sender, never to a dead port
    aMaskLegal: assert property (@(posedge RxClk) disable iff (!rstN)
      (fwdMask[i] & ((N'(1) << i) | ~portActive)) == '0)
      else $error("forwardTable: bad mask %b on in-port %0d", fwdMask[i], i);
  end

endmodule

// File: hw/frameReceiver.sv
// Per-port receiver: SFD search, address capture and a 14-byte delay line
// Frames need 12+ idle cycles between them so the held addresses
// stay valid until the delayed tail has left
`timescale 1ns/1ps
`include "ethSwitch_defs.svh"

module frameReceiver (
  input  logic                     RxClk,
  input  logic                     rstN,
  input  ethSwitchPkg::rxByteS     rx,
  output ethSwitchPkg::switchWordS stream,
  output ethSwitchPkg::macAddrU    destMac,
  output ethSwitchPkg::macAddrU    srcMac,
  output logic                     headerDone
);

  localparam int DLY        = `HDR_BYTES;
  localparam int ADDR_BYTES = 12;                 // Dest + source MAC
  localparam int CW         = $clog2(`HDR_BYTES);

  typedef enum logic [1:0] {
    RX_IDLE   = 2'd0,
    RX_HEADER = 2'd1,
    RX_DATA   = 2'd2
  } rxStateE;

  rxStateE            state;
  logic [CW-1:0]      hdrCnt;                     // Byte index within header
  logic [`BYTE_W-1:0] hdrByte [0:ADDR_BYTES-1];   // Type field is counted, not kept

  // Valid line is one stage longer for edge detection
  logic [DLY:0]                  vldDly;
  logic [DLY-1:0][`BYTE_W-1:0]   dataDly;
  logic [DLY-1:0]                errDly;
  logic                          isFirst;
  logic                          isLast;

  // Delay line
  always_ff @(posedge RxClk) begin
    if (!rstN) begin
      vldDly <= '0;
    end else begin
      vldDly <= {vldDly[DLY-1:0], rx.valid};
    end
  end

  always_ff @(posedge RxClk) begin
    dataDly <= {dataDly[DLY-2:0], rx.data};
    errDly  <= {errDly[DLY-2:0], rx.err};
  end

  // Header FSM
  always_ff @(posedge RxClk) begin
    if (!rstN) begin
      state      <= RX_IDLE;
      hdrCnt     <= '0;
      headerDone <= 1'b0;
    end else begin
      headerDone <= 1'b0;                         // One-cycle strobe
      case (state)
        RX_IDLE: begin
          // Preamble is not checked, only the delimiter
          if (rx.valid && rx.data == `SFD_BYTE) begin
            state  <= RX_HEADER;
            hdrCnt <= '0;
          end
        end
        RX_HEADER: begin
          if (!rx.valid) begin
            state <= RX_IDLE;                     // Runt frame
          end else begin
            hdrCnt <= hdrCnt + 1'b1;
            if (hdrCnt == CW'(`HDR_BYTES - 1)) begin
              state      <= RX_DATA;
              headerDone <= 1'b1;
            end
          end
        end
        RX_DATA: begin
          if (!rx.valid) state <= RX_IDLE;        // End of frame
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // Address bytes, first on the wire is most significant
  always_ff @(posedge RxClk) begin
    if (state == RX_HEADER && rx.valid && hdrCnt < CW'(ADDR_BYTES)) begin
      hdrByte[hdrCnt] <= rx.data;
    end
  end

  assign destMac.raw = {hdrByte[0], hdrByte[1], hdrByte[2],
                        hdrByte[3], hdrByte[4], hdrByte[5]};
  assign srcMac.raw  = {hdrByte[6], hdrByte[7], hdrByte[8],
                        hdrByte[9], hdrByte[10], hdrByte[11]};

  // Byte status at the delay-line output
  assign isFirst = vldDly[DLY-1] & ~vldDly[DLY];    // Rising valid
  assign isLast  = vldDly[DLY-1] & ~vldDly[DLY-2];  // Falling valid next

  always_comb begin
    stream.valid = vldDly[DLY-1];
    stream.data  = dataDly[DLY-1];
    if (isFirst) begin
      stream.st = ethSwitchPkg::ST_FIRST;
    end else if (isLast) begin
      stream.st = ethSwitchPkg::ST_LAST;
    end else if (errDly[DLY-1]) begin
      stream.st = ethSwitchPkg::ST_ERR;
    end else begin
      stream.st = ethSwitchPkg::ST_PLAIN;
    end
  end

  aStateLegal: assert property (@(posedge RxClk) disable iff (!rstN)
    state inside {RX_IDLE, RX_HEADER, RX_DATA})
    else $error("frameReceiver: illegal state %0d", state);

endmodule

// File: hw/packetFifo.sv
// Byte FIFO for one in/out pair with a count of complete packets
// Registered read; no overflow handling, depth must cover a full frame
`timescale 1ns/1ps
`include "ethSwitch_defs.svh"

module packetFifo (
  input  logic                     RxClk,
  input  logic                     rstN,
  input  logic                     flush,     // Out-port inactive
  input  logic                     wrEn,
  input  ethSwitchPkg::switchWordS wrWord,
  input  logic                     rdEn,
  output ethSwitchPkg::switchWordS rdWord,
  output logic                     pktAvail
);

  localparam int AW = $clog2(`FIFO_DEPTH);
  localparam int CW = AW + 1;

  ethSwitchPkg::switchWordS mem [`FIFO_DEPTH];
  ethSwitchPkg::switchWordS rdEntry;   // Read data register
  logic                     rdValid;
  logic [AW-1:0]            wrPtr;
  logic [AW-1:0]            rdPtr;
  logic [CW-1:0]            used;
  logic [CW-1:0]            pktCnt;
  logic                     wrLast;
  logic                     rdLast;

  assign wrLast = wrEn && wrWord.st == ethSwitchPkg::ST_LAST;
  assign rdLast = rdEn && mem[rdPtr].st == ethSwitchPkg::ST_LAST;  // Peek at head

  always_ff @(posedge RxClk) begin
    if (!rstN || flush) begin
      wrPtr   <= '0;
      rdPtr   <= '0;
      used    <= '0;
      pktCnt  <= '0;
      rdValid <= 1'b0;
    end else begin
      if (wrEn) wrPtr <= wrPtr + 1'b1;
      if (rdEn) rdPtr <= rdPtr + 1'b1;
      used    <= used + CW'(wrEn) - CW'(rdEn);
      pktCnt  <= pktCnt + CW'(wrLast) - CW'(rdLast);
      rdValid <= rdEn;                           // Data shows one cycle after strobe
    end
  end

  always_ff @(posedge RxClk) begin
    if (wrEn) mem[wrPtr] <= wrWord;
    if (rdEn) rdEntry <= mem[rdPtr];
  end

  assign rdWord.valid = rdValid & rdEntry.valid;
  assign rdWord.st    = rdEntry.st;
  assign rdWord.data  = rdEntry.data;
  assign pktAvail     = pktCnt != '0;            // Only whole packets are offered

  aNoOverflow: assert property (@(posedge RxClk) disable iff (!rstN)
    wrEn && !flush |-> used != CW'(`FIFO_DEPTH))
    else $error("packetFifo: write while full");

  aNoUnderflow: assert property (@(posedge RxClk) disable iff (!rstN)
    rdEn && !flush |-> used != '0)
    else $error("packetFifo: read while empty");

endmodule

// File: hw/txScheduler.sv
// Round-robin scheduler for one out-port over its three in-port FIFOs
// Starts only on fully queued packets, then reads them out back to back
// At least IPG_BYTES idle cycles follow every packet
`timescale 1ns/1ps
`include "ethSwitch_defs.svh"

module txScheduler (
  input  logic                     RxClk,
  input  logic                     rstN,
  input  logic [`NUM_PORTS-1:0]    pktAvail,   // Own index tied low
  input  ethSwitchPkg::switchWordS rdWord [`NUM_PORTS],
  output logic [`NUM_PORTS-1:0]    rdEn,
  output ethSwitchPkg::txByteS     tx
);

  localparam int PW = $clog2(`NUM_PORTS);
  localparam int GW = $clog2(`IPG_BYTES + 1);

  logic [PW-1:0]            cur;       // Current or last served in-port
  logic                     active;
  logic [GW-1:0]            gapCnt;
  logic [PW-1:0]            pick;
  logic [PW-1:0]            cand;
  logic                     found;
  logic                     canStart;
  logic                     moreData;
  ethSwitchPkg::switchWordS selWord;

  assign selWord = rdWord[cur];

  // Next in-port after cur with a queued packet, cur itself last
  always_comb begin
    pick  = cur;
    found = 1'b0;
    for (int k = 1; k <= `NUM_PORTS; k++) begin
      cand = cur + PW'(k);
      if (!found && pktAvail[cand]) begin
        pick  = cand;
        found = 1'b1;
      end
    end
  end

  assign canStart = !active && gapCnt == '0 && found;
  // Keep reading while the word on the bus is not the last one;
  // a missing word means the FIFO was flushed under us
  assign moreData = active && selWord.valid && selWord.st != ethSwitchPkg::ST_LAST;

  always_comb begin
    rdEn = '0;
    if (moreData) begin
      rdEn[cur] = 1'b1;
    end else if (canStart) begin
      rdEn[pick] = 1'b1;                       // First read in the select cycle
    end
  end

  always_ff @(posedge RxClk) begin
    if (!rstN) begin
      cur    <= '0;
      active <= 1'b0;
      gapCnt <= '0;
    end else if (active) begin
      if (!moreData) begin
        active <= 1'b0;                        // Last byte is on tx now
        gapCnt <= GW'(`IPG_BYTES);
      end
    end else if (gapCnt != '0) begin
      gapCnt <= gapCnt - 1'b1;
    end else if (found) begin
      cur    <= pick;
      active <= 1'b1;
    end
  end

  // Output straight from the selected FIFO register
  assign tx.en   = selWord.valid;
  assign tx.data = selWord.data;
  assign tx.err  = selWord.valid && selWord.st == ethSwitchPkg::ST_ERR;

endmodule

// File: runSim.sh
#!/bin/sh
# Build with Verilator and run; exit status is the test result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f ethSwitch.f --top-module ethSwitchTb -o ethSwitchSim &&
./obj_dir/ethSwitchSim ||
{ echo "Simulation failed"; exit 1; }

// File: tb/ethSwitchTb.sv
// Testbench for the four-port switch, one frame group at a time
// Each group waits for all expected bytes, then a quiet window, then checks
// Pairs of frames are sent at once and may leave an out-port in either order
`timescale 1ns/1ps
`include "ethSwitch_defs.svh"

module ethSwitchTb;

  localparam int NUM_ENT  = 11;
  localparam int MAX_LEN  = 80;
  localparam int PRE_LEN  = 8;                    // Preamble plus SFD
  localparam int IDLE_CYC = 16;                   // Idle cycles after each frame group
  localparam int DRAIN    = 50;                   // Quiet window before checking
  localparam int MARGIN   = 500;

  localparam logic [3:0]  BOARD   = 4'h3;
  localparam logic [1:0]  P_ETH1  = 2'(`ETH1_IDX);
  localparam logic [1:0]  P_ETH2  = 2'(`ETH2_IDX);
  localparam logic [1:0]  P_PS    = 2'(`PS_IDX);
  localparam logic [1:0]  P_RT    = 2'(`RT_IDX);
  localparam logic [7:0]  NO_ERR  = 8'hff;
  localparam logic [47:0] BCAST   = `BROADCAST_MAC;
  localparam logic [47:0] PS_ADDR = {`LCSR_CID, `PS_IFACE, 4'h0, BOARD};
  localparam logic [47:0] RT_ADDR = {`LCSR_CID, `RT_IFACE, 4'h0, BOARD};
  localparam logic [47:0] B5_ADDR = {`LCSR_CID, `PS_IFACE, 4'h0, 4'h5};  // Remote board 5
  // Other interface on board 5, never a learned host address
  localparam logic [47:0] B5_RT   = {`LCSR_CID, `RT_IFACE, 4'h0, 4'h5};
  localparam logic [47:0] HOST_A  = 48'h02_11_11_11_11_11;
  localparam logic [47:0] HOST_X  = 48'h02_22_22_22_22_22;
  localparam logic [47:0] UNK1    = 48'h02_00_00_00_00_99;
  localparam logic [47:0] UNK2    = 48'h02_00_00_00_00_77;

  // One table row per frame
  typedef struct packed {
    logic [1:0]  inPort;
    logic [47:0] dst;
    logic [47:0] src;
    logic [7:0]  payLen;
    logic [7:0]  errPos;     // Byte offset in the whole frame, NO_ERR for none
    logic [3:0]  expMask;    // Out-ports that must see the frame
    logic [3:0]  active;     // portActive while this frame runs
    logic        pairNext;   // Send together with the next row
  } frameEntryS;

  // One captured tx byte
  typedef struct packed {
    logic [21:0] cyc;
    logic        err;
    logic [7:0]  data;
  } monByteS;

  logic                  RxClk;
  logic                  rstN;
  ethSwitchPkg::rxByteS  rxIn  [`NUM_PORTS];
  ethSwitchPkg::txByteS  txOut [`NUM_PORTS];
  logic [`NUM_PORTS-1:0] portActive;
  logic [3:0]            boardId;

  frameEntryS  tab      [NUM_ENT];
  logic [7:0]  frameMem [NUM_ENT][MAX_LEN];
  monByteS     outQ     [`NUM_PORTS][$];
  int          base     [`NUM_PORTS];          // First unchecked entry per port
  logic [21:0] cycle = '0;
  int          seed;

  ethSwitch dut (
    .RxClk      (RxClk),
    .rstN       (rstN),
    .rx         (rxIn),
    .portActive (portActive),
    .boardId    (boardId),
    .tx         (txOut)
  );

  initial begin
    RxClk = 1'b0;
    forever #50 RxClk = ~RxClk;
  end

  always @(posedge RxClk) cycle <= cycle + 22'd1;

  // Monitors, one per tx port
  always @(posedge RxClk) begin
    for (int p = 0; p < `NUM_PORTS; p++) begin
      if (txOut[p].en) outQ[p].push_back('{cyc: cycle, err: txOut[p].err, data: txOut[p].data});
    end
  end

  function automatic int frameLen(input int k);
    return PRE_LEN + `HDR_BYTES + int'(tab[k].payLen);
  endfunction

  task automatic fillTable();
    // Before any learning an unknown unicast floods to both Eth ports
    tab[0]  = '{P_PS,   UNK1,    PS_ADDR, 8'd20, NO_ERR, 4'b0011, 4'hf, 1'b0};
    tab[1]  = '{P_ETH1, BCAST,   HOST_A,  8'd32, NO_ERR, 4'b1110, 4'hf, 1'b0};
    tab[2]  = '{P_ETH1, PS_ADDR, HOST_A,  8'd24, NO_ERR, 4'b0100, 4'hf, 1'b0};
    tab[3]  = '{P_ETH2, RT_ADDR, HOST_X,  8'd28, NO_ERR, 4'b1000, 4'hf, 1'b0};  // Learns X
    tab[4]  = '{P_RT,   HOST_X,  RT_ADDR, 8'd26, NO_ERR, 4'b0010, 4'hf, 1'b0};
    tab[5]  = '{P_ETH1, BCAST,   B5_ADDR, 8'd30, NO_ERR, 4'b1110, 4'hf, 1'b0};  // Board 5 on Eth1
    tab[6]  = '{P_PS,   B5_RT,   PS_ADDR, 8'd36, NO_ERR, 4'b0001, 4'hf, 1'b0};
    tab[7]  = '{P_ETH2, BCAST,   HOST_X,  8'd40, 8'd30,  4'b1101, 4'hf, 1'b0};
    tab[8]  = '{P_PS,   UNK2,    PS_ADDR, 8'd30, NO_ERR, 4'b0011, 4'hf, 1'b1};  // Concurrent pair
    tab[9]  = '{P_RT,   UNK2,    RT_ADDR, 8'd45, NO_ERR, 4'b0011, 4'hf, 1'b0};
    tab[10] = '{P_ETH1, BCAST,   HOST_A,  8'd34, NO_ERR, 4'b0110, 4'h7, 1'b0};  // RT inactive
  endtask

  // Preamble, SFD, header MSB first, type, random payload
  task automatic buildFrames();
    for (int k = 0; k < NUM_ENT; k++) begin
      for (int i = 0; i < 7; i++) frameMem[k][i] = 8'h55;
      frameMem[k][7] = `SFD_BYTE;
      for (int i = 0; i < 6; i++) begin
        frameMem[k][PRE_LEN + i]     = tab[k].dst[47 - 8*i -: 8];
        frameMem[k][PRE_LEN + 6 + i] = tab[k].src[47 - 8*i -: 8];
      end
      frameMem[k][PRE_LEN + 12] = 8'h08;          // IPv4 type
      frameMem[k][PRE_LEN + 13] = 8'h00;
      for (int i = PRE_LEN + `HDR_BYTES; i < frameLen(k); i++) frameMem[k][i] = 8'($random(seed));
    end
  endtask

  task automatic driveFrame(input int k);
    int p;
    int len;
    p   = int'(tab[k].inPort);
    len = frameLen(k);
    for (int i = 0; i < len; i++) begin
      @(posedge RxClk);
      rxIn[p].valid <= 1'b1;
      rxIn[p].data  <= frameMem[k][i];
      rxIn[p].err   <= (i == int'(tab[k].errPos));
    end
    @(posedge RxClk);
    rxIn[p] <= '0;
  endtask

  task automatic checkEq(input string name, input int expVal, input int actVal);
    if (expVal != actVal) begin
      $display("Mismatch %s: expected 0x%0h, actual 0x%0h", name, expVal, actVal);
      $display("** FAIL **");
      $fatal(1, "Check failed at cycle %0d", cycle);
    end
  endtask

  // Bytes port p must see from rows first..first+n-1
  function automatic int expBytes(input int p, input int first, input int n);
    int sum;
    sum = 0;
    for (int j = first; j < first + n; j++) begin
      if (tab[j].expMask[p]) sum += frameLen(j);
    end
    return sum;
  endfunction

  function automatic bit outputsDone(input int first, input int n);
    for (int p = 0; p < `NUM_PORTS; p++) begin
      if (outQ[p].size() - base[p] < expBytes(p, first, n)) return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic checkPort(input int p, input int first, input int n);
    int eIdx [2];
    int nExp;
    int nPkt;
    int firstLen;
    int idle;
    int pos;
    int e;
    nExp     = 0;
    nPkt     = 0;
    firstLen = 0;
    for (int j = first; j < first + n; j++) begin
      if (tab[j].expMask[p]) begin
        eIdx[nExp] = j;
        nExp++;
      end
    end
    checkEq($sformatf("tx[%0d] byte count", p), expBytes(p, first, n), outQ[p].size() - base[p]);
    // Split into packets at breaks in the cycle count
    for (int i = base[p]; i < outQ[p].size(); i++) begin
      if (i == base[p] || outQ[p][i].cyc != outQ[p][i-1].cyc + 22'd1) begin
        nPkt++;
        if (i != base[p]) begin
          idle = int'(outQ[p][i].cyc) - int'(outQ[p][i-1].cyc) - 1;
          checkEq($sformatf("tx[%0d] gap below IPG", p), 0, int'(idle < `IPG_BYTES));
        end
      end
      if (nPkt == 1) firstLen++;
    end
    checkEq($sformatf("tx[%0d] packets", p), nExp, nPkt);
    if (nExp == 2 && firstLen != frameLen(eIdx[0])) begin
      e       = eIdx[0];                          // Other frame won arbitration
      eIdx[0] = eIdx[1];
      eIdx[1] = e;
    end
    if (nExp > 0) checkEq($sformatf("tx[%0d] first length", p), frameLen(eIdx[0]), firstLen);
    pos = base[p];
    for (int j = 0; j < nExp; j++) begin
      e = eIdx[j];
      for (int i = 0; i < frameLen(e); i++) begin
        checkEq($sformatf("tx[%0d].data row %0d byte %0d", p, e, i),
                int'(frameMem[e][i]), int'(outQ[p][pos].data));
        checkEq($sformatf("tx[%0d].err row %0d byte %0d", p, e, i),
                int'(i == int'(tab[e].errPos)), int'(outQ[p][pos].err));
        pos++;
      end
    end
    base[p] = outQ[p].size();
  endtask

  // Send one row or a pair, wait for every out-port, then check
  task automatic runGroup(input int first, input int n);
    @(posedge RxClk);
    portActive <= tab[first].active;
    if (n == 2) begin
      fork
        driveFrame(first);
        driveFrame(first + 1);
      join
    end else begin
      driveFrame(first);
    end
    repeat (IDLE_CYC) @(posedge RxClk);
    while (!outputsDone(first, n)) @(posedge RxClk);
    repeat (DRAIN) @(posedge RxClk);              // Catch stray bytes
    for (int p = 0; p < `NUM_PORTS; p++) checkPort(p, first, n);
  endtask

  task automatic watchdog(input int limit);
    repeat (limit) @(posedge RxClk);
    $display("** FAIL **");
    $fatal(1, "Timeout: frames did not finish within %0d cycles", limit);
  endtask

  initial begin
    int k;
    int n;
    int total;
    rstN       <= 1'b0;
    portActive <= 4'hf;
    boardId    <= BOARD;
    for (int p = 0; p < `NUM_PORTS; p++) begin
      rxIn[p] <= '0;
      base[p] = 0;
    end
    seed = 91661;
    fillTable();
    buildFrames();
    total = 0;
    for (int j = 0; j < NUM_ENT; j++) total += frameLen(j) + IDLE_CYC + DRAIN + 8;
    fork
      watchdog(2 * total + MARGIN);
    join_none
    repeat (3) @(posedge RxClk);
    rstN <= 1'b1;
    k = 0;
    while (k < NUM_ENT) begin
      n = tab[k].pairNext ? 2 : 1;
      runGroup(k, n);
      k += n;
    end
    $display("** PASS **");
    $finish;
  end

endmodule
